//--- status_pkg.sv
package status_pkg;

    // request width limit of the largest counter kept
    localparam int MAX_REQ_W = 31;
    // channel limit of one router port
    localparam int MAX_VC_NUM = 8;

    // field widths
    localparam int COUNT_W = 5;
    localparam int OCC_W = 5;
    localparam int VC_IDX_W = 3;
    localparam int SUM_W = 6;
    localparam int CSA_W = 3;

    // number of set request bits, 0 to 31
    typedef logic [COUNT_W-1:0] count_t;

    // buffer occupancy of one virtual channel
    typedef logic [OCC_W-1:0] occ_t;

    // binary channel index
    typedef logic [VC_IDX_W-1:0] vc_idx_t;

    // total occupancy, clamps at all ones
    typedef logic [SUM_W-1:0] sum_t;

    // three weight-two carries of one carry-sum block
    typedef logic [CSA_W-1:0] csa_abc_t;

    // registered result of one strobe
    // msb first, 15 bits in total
    typedef struct packed {
        count_t  req_count;
        logic    req_single;
        vc_idx_t min_idx;
        sum_t    occ_total;
    } status_t;

endpackage

//--- carry_sum_gen.sv
`timescale 1ns/1ps

module carry_sum_gen (
    input  logic [6:0]          in_bits,
    output status_pkg::csa_abc_t abc,
    output logic                s
);
    import status_pkg::*;

    // low group of four, high group of three
    logic [3:0] grp_lo;
    logic [2:0] grp_hi;
    // ones in each group
    logic [2:0] ones_lo;
    logic [1:0] ones_hi;

    assign grp_lo = in_bits[3:0];
    assign grp_hi = in_bits[6:4];

    assign ones_lo = {2'b00, grp_lo[0]} + {2'b00, grp_lo[1]}
                   + {2'b00, grp_lo[2]} + {2'b00, grp_lo[3]};
    assign ones_hi = {1'b0, grp_hi[0]} + {1'b0, grp_hi[1]} + {1'b0, grp_hi[2]};

    // parity of the whole block
    assign s = ones_lo[0] ^ ones_hi[0];

    // a when the low group holds two or more
    assign abc[2] = (ones_lo > 3'd1);
    // b when the high group holds two or more
    assign abc[1] = (ones_hi > 2'd1);
    // c covers four in the low group, or two odd groups
    // that pair up into one more carry
    assign abc[0] = (ones_lo == 3'd4) | (ones_lo[0] & ones_hi[0]);

endmodule

//--- pop_count_15.sv
`timescale 1ns/1ps

module pop_count_15 (
    input  logic [14:0] in_bits,
    output logic [3:0]  count
);
    import status_pkg::*;

    // first level carries and parities
    csa_abc_t abc_lo;
    csa_abc_t abc_hi;
    logic     s_lo;
    logic     s_hi;
    // last bit plus both parities
    logic [1:0] tail_sum;
    // second level block on the weight-two bits
    csa_abc_t abc_top;
    logic     s_top;

    carry_sum_gen u_csa_lo (
        .in_bits (in_bits[6:0]),
        .abc     (abc_lo),
        .s       (s_lo)
    );

    carry_sum_gen u_csa_hi (
        .in_bits (in_bits[13:7]),
        .abc     (abc_hi),
        .s       (s_hi)
    );

    // weight-one column
    assign tail_sum = {1'b0, in_bits[14]} + {1'b0, s_lo} + {1'b0, s_hi};
    assign count[0] = tail_sum[0];

    // six carries and the tail carry, all weight two
    carry_sum_gen u_csa_top (
        .in_bits ({abc_lo, abc_hi, tail_sum[1]}),
        .abc     (abc_top),
        .s       (s_top)
    );

    // (7,3) step folded in here
    assign count[1] = s_top;
    assign count[3:2] = {1'b0, abc_top[2]} + {1'b0, abc_top[1]} + {1'b0, abc_top[0]};

endmodule

//--- pop_count_31.sv
`timescale 1ns/1ps

module pop_count_31 (
    input  logic [30:0]          in_bits,
    output status_pkg::count_t   count
);
    import status_pkg::*;

    localparam int CHAIN_N = 4;

    // parities of the first four blocks
    logic [CHAIN_N-1:0] s_chain;
    // parity of the closing block, weight one
    logic               s_last;
    // fifteen weight-two carries
    logic [14:0]        abc_bits;
    // count of the carries
    logic [3:0]         carry_count;

    // four blocks over in_bits[27:0]
    genvar i;
    generate
        for (i = 0; i < CHAIN_N; i = i + 1) begin : g_csa
            carry_sum_gen u_csa (
                .in_bits (in_bits[i*7 +: 7]),
                .abc     (abc_bits[i*3 +: 3]),
                .s       (s_chain[i])
            );
        end
    endgenerate

    // closing block takes the top three inputs
    // and the four parities of the chain
    carry_sum_gen u_csa_last (
        .in_bits ({s_chain, in_bits[30:28]}),
        .abc     (abc_bits[14:12]),
        .s       (s_last)
    );

    // carries weigh two, so their count shifts up by one
    pop_count_15 u_pop_count_15 (
        .in_bits (abc_bits),
        .count   (carry_count)
    );

    assign count = {carry_count, s_last};

endmodule

//--- request_counter.sv
`timescale 1ns/1ps

module request_counter #(
    parameter int REQ_W = 24
) (
    input  logic [REQ_W-1:0]     req,
    output status_pkg::count_t   req_count,
    output logic                 req_single
);
    import status_pkg::*;

    // smallest kept counter that covers the request vector
    localparam int PC_W = (REQ_W < 16) ? 15 : 31;

    // zero-padded counter input
    logic [PC_W-1:0] pc_in;

    always_comb begin
        pc_in = '0;
        pc_in[REQ_W-1:0] = req;
    end

    generate
        if (PC_W == 15) begin : g_pc15
            // four-bit result widened to count_t
            logic [3:0] cnt15;

            pop_count_15 u_pop_count (
                .in_bits (pc_in),
                .count   (cnt15)
            );

            assign req_count = count_t'(cnt15);
        end else begin : g_pc31
            pop_count_31 u_pop_count (
                .in_bits (pc_in),
                .count   (req_count)
            );
        end
    endgenerate

    // zero or one request set
    assign req_single = (req_count <= count_t'(1));

endmodule

//--- min_finder.sv
`timescale 1ns/1ps

module min_finder #(
    parameter int VC_NUM = 4
) (
    input  status_pkg::occ_t [VC_NUM-1:0] occ,
    output logic [VC_NUM-1:0]             min_onehot
);
    import status_pkg::*;

    // le_pair[i][j] holds occ[i] <= occ[j]
    // only the upper triangle j > i is built
    logic [VC_NUM-1:0][VC_NUM-1:0] le_pair;

    always_comb begin
        le_pair = '0;
        for (int i = 0; i < VC_NUM; i++) begin
            for (int j = i + 1; j < VC_NUM; j++) begin
                le_pair[i][j] = (occ[i] <= occ[j]);
            end
        end
    end

    // channel i wins when not above any later channel
    // and strictly below every earlier one
    always_comb begin
        logic win;
        for (int i = 0; i < VC_NUM; i++) begin
            win = 1'b1;
            for (int j = 0; j < VC_NUM; j++) begin
                if (j > i) begin
                    win = win & le_pair[i][j];
                end else if (j < i) begin
                    // lower triangle, inverse of the mirrored pair
                    win = win & ~le_pair[j][i];
                end
            end
            min_onehot[i] = win;
        end
    end

endmodule

//--- onehot_encoder.sv
`timescale 1ns/1ps

module onehot_encoder #(
    parameter int VC_NUM = 4
) (
    input  logic [VC_NUM-1:0]   onehot,
    output status_pkg::vc_idx_t idx
);
    import status_pkg::*;

    // constant index per channel
    vc_idx_t [VC_NUM-1:0] idx_table;
    // table entries gated by their select bit
    vc_idx_t [VC_NUM-1:0] idx_masked;

    genvar i;
    generate
        for (i = 0; i < VC_NUM; i = i + 1) begin : g_entry
            assign idx_table[i] = vc_idx_t'(i);
            // replicate select across the entry
            assign idx_masked[i] = idx_table[i] & {VC_IDX_W{onehot[i]}};
        end
    endgenerate

    // only one entry survives the mask, so an or picks it
    always_comb begin
        idx = '0;
        for (int k = 0; k < VC_NUM; k++) begin
            idx = idx | idx_masked[k];
        end
    end

endmodule

//--- occupancy_sum.sv
`timescale 1ns/1ps

module occupancy_sum #(
    parameter int VC_NUM = 4
) (
    input  status_pkg::occ_t [VC_NUM-1:0] occ,
    output status_pkg::sum_t              occ_total
);
    import status_pkg::*;

    // one spare bit keeps the overflow slice non-empty
    localparam int FULL_W = OCC_W + $clog2(VC_NUM) + 1;

    logic [FULL_W-1:0] full_sum;
    logic              overflow;

    // plain adder chain
    always_comb begin
        full_sum = '0;
        for (int k = 0; k < VC_NUM; k++) begin
            full_sum = full_sum + FULL_W'(occ[k]);
        end
    end

    // anything above sum_t means clamp
    assign overflow = |full_sum[FULL_W-1:SUM_W];

    assign occ_total = overflow ? '1 : full_sum[SUM_W-1:0];

endmodule

//--- vc_status_unit.sv
`timescale 1ns/1ps

module vc_status_unit #(
    parameter int REQ_W = 24,
    parameter int VC_NUM = 4
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           in_valid,
    input  logic [REQ_W-1:0]               req,
    input  status_pkg::occ_t [VC_NUM-1:0]  occ,
    output logic                           out_valid,
    output status_pkg::status_t            status,
    output logic [VC_NUM-1:0]              min_onehot
);
    import status_pkg::*;

    // width limits of the counters and the index type
    if (REQ_W < 1 || REQ_W > MAX_REQ_W) begin : g_bad_req_w
        $error("REQ_W out of range");
    end
    if (VC_NUM < 2 || VC_NUM > MAX_VC_NUM) begin : g_bad_vc_num
        $error("VC_NUM out of range");
    end

    // combinational results of the current strobe
    status_t            status_c;
    logic [VC_NUM-1:0]  min_onehot_c;

    request_counter #(
        .REQ_W (REQ_W)
    ) u_request_counter (
        .req        (req),
        .req_count  (status_c.req_count),
        .req_single (status_c.req_single)
    );

    min_finder #(
        .VC_NUM (VC_NUM)
    ) u_min_finder (
        .occ        (occ),
        .min_onehot (min_onehot_c)
    );

    onehot_encoder #(
        .VC_NUM (VC_NUM)
    ) u_onehot_encoder (
        .onehot (min_onehot_c),
        .idx    (status_c.min_idx)
    );

    occupancy_sum #(
        .VC_NUM (VC_NUM)
    ) u_occupancy_sum (
        .occ       (occ),
        .occ_total (status_c.occ_total)
    );

    // single output stage, valid follows the strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            status     <= '0;
            min_onehot <= '0;
        end else begin
            out_valid <= in_valid;
            // payload only moves on a strobe
            if (in_valid) begin
                status     <= status_c;
                min_onehot <= min_onehot_c;
            end
        end
    end

    // winner vector from min_finder must stay one-hot
    a_min_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> $onehot(min_onehot)
    ) else $error("min_onehot not one-hot");

    // every result traces back to a strobe one edge earlier
    a_valid_follows_strobe: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> $past(in_valid)
    ) else $error("out_valid without strobe");

    // flag and count come from the same counter tree
    a_single_matches_count: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> (status.req_single == (status.req_count <= count_t'(1)))
    ) else $error("req_single disagrees with req_count");

endmodule

//--- tb_vc_status_unit.sv
`timescale 1ns/1ps

module tb_vc_status_unit;
    import status_pkg::*;

    localparam int REQ_W = 24;
    localparam int VC_NUM = 4;
    localparam int N_DIRECTED = 8;
    localparam int N_RANDOM = 48;
    localparam int DRAIN_LIMIT = 10;

    // one stimulus row with its expected results
    typedef struct {
        logic [REQ_W-1:0]  req;
        occ_t [VC_NUM-1:0] occ;
        count_t            exp_count;
        logic              exp_single;
        vc_idx_t           exp_idx;
        sum_t              exp_total;
        int                gap;
    } row_t;

    logic               clk = 1'b0;
    logic               arst_n;
    logic               in_valid;
    logic [REQ_W-1:0]   req;
    occ_t [VC_NUM-1:0]  occ;
    logic               out_valid;
    status_t            status;
    logic [VC_NUM-1:0]  min_onehot;

    row_t        directed [N_DIRECTED];
    // row whose results are due at the next check
    row_t        pend_row;
    logic        pend_valid;
    // output register holds a row since the first strobe
    logic        loaded;
    logic [15:0] lfsr_state;

    vc_status_unit #(
        .REQ_W  (REQ_W),
        .VC_NUM (VC_NUM)
    ) u_vc_status_unit (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .req        (req),
        .occ        (occ),
        .out_valid  (out_valid),
        .status     (status),
        .min_onehot (min_onehot)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // reports the first mismatch and stops
    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
        $display("sim failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_count(input count_t got, input count_t exp, input string name);
        if (got !== exp) report_mismatch(name, int'(got), int'(exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) report_mismatch(name, int'(got), int'(exp));
    endtask

    task automatic check_idx(input vc_idx_t got, input vc_idx_t exp, input string name);
        if (got !== exp) report_mismatch(name, int'(got), int'(exp));
    endtask

    task automatic check_total(input sum_t got, input sum_t exp, input string name);
        if (got !== exp) report_mismatch(name, int'(got), int'(exp));
    endtask

    task automatic check_onehot(input logic [VC_NUM-1:0] got, input logic [VC_NUM-1:0] exp,
                                input string name);
        if (got !== exp) report_mismatch(name, int'(got), int'(exp));
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] st);
        logic [15:0] nxt;
        nxt = st >> 1;
        if (st[0]) nxt = nxt ^ 16'hB400;
        return nxt;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // reference model
    function automatic count_t ref_count(input logic [REQ_W-1:0] r);
        int n;
        n = 0;
        for (int i = 0; i < REQ_W; i++) n = n + int'(r[i]);
        return count_t'(n);
    endfunction

    // strict compare keeps the lowest index on ties
    function automatic vc_idx_t ref_min_idx(input occ_t [VC_NUM-1:0] o);
        int best;
        int idx;
        best = int'(o[0]);
        idx = 0;
        for (int c = 1; c < VC_NUM; c++) begin
            if (int'(o[c]) < best) begin
                best = int'(o[c]);
                idx = c;
            end
        end
        return vc_idx_t'(idx);
    endfunction

    function automatic sum_t ref_total(input occ_t [VC_NUM-1:0] o);
        int t;
        t = 0;
        for (int c = 0; c < VC_NUM; c++) t = t + int'(o[c]);
        if (t > 63) return '1;
        return sum_t'(t);
    endfunction

    // occ written as {ch3, ch2, ch1, ch0}
    task automatic load_directed();
        directed[0] = '{24'h000000, {5'd3, 5'd9, 5'd1, 5'd7}, 5'd0, 1'b1, 3'd1, 6'd20, 0};
        directed[1] = '{24'h000001, {5'd5, 5'd5, 5'd5, 5'd5}, 5'd1, 1'b1, 3'd0, 6'd20, 1};
        directed[2] = '{24'hFFFFFF, {5'd31, 5'd31, 5'd31, 5'd31}, 5'd24, 1'b0, 3'd0, 6'd63, 0};
        directed[3] = '{24'hAAAAAA, {5'd2, 5'd4, 5'd6, 5'd8}, 5'd12, 1'b0, 3'd3, 6'd20, 0};
        directed[4] = '{24'h555555, {5'd0, 5'd0, 5'd10, 5'd10}, 5'd12, 1'b0, 3'd2, 6'd20, 2};
        directed[5] = '{24'h800000, {5'd16, 5'd15, 5'd16, 5'd17}, 5'd1, 1'b1, 3'd2, 6'd63, 0};
        directed[6] = '{24'h000003, {5'd16, 5'd15, 5'd16, 5'd16}, 5'd2, 1'b0, 3'd2, 6'd63, 1};
        directed[7] = '{24'h0F0F00, {5'd31, 5'd0, 5'd31, 5'd0}, 5'd8, 1'b0, 3'd0, 6'd62, 0};
    endtask

    task automatic make_random_row(output row_t r);
        logic [31:0] v;
        draw_bits(REQ_W, v);
        r.req = v[REQ_W-1:0];
        for (int c = 0; c < VC_NUM; c++) begin
            draw_bits(OCC_W, v);
            r.occ[c] = v[OCC_W-1:0];
        end
        r.exp_count = ref_count(r.req);
        r.exp_single = (int'(r.exp_count) <= 1);
        r.exp_idx = ref_min_idx(r.occ);
        r.exp_total = ref_total(r.occ);
        // roughly one row in four is followed by a gap
        draw_bits(2, v);
        r.gap = (v[1:0] == 2'b11) ? 2 : 0;
    endtask

    task automatic check_idle_zero();
        check_flag(out_valid, 1'b0, "out_valid");
        check_count(status.req_count, '0, "status.req_count");
        check_flag(status.req_single, 1'b0, "status.req_single");
        check_idx(status.min_idx, '0, "status.min_idx");
        check_total(status.occ_total, '0, "status.occ_total");
        check_onehot(min_onehot, '0, "min_onehot");
    endtask

    // drive on the rising edge, check the previous strobe at the falling edge
    task automatic run_cycle(input logic drive_valid, input row_t r);
        logic [VC_NUM-1:0] exp_oh;
        @(posedge clk);
        in_valid <= drive_valid;
        if (drive_valid) begin
            req <= r.req;
            occ <= r.occ;
        end else begin
            // junk while idle, register must ignore it
            req <= ~r.req;
            occ <= ~r.occ;
        end
        @(negedge clk);
        check_flag(out_valid, pend_valid, "out_valid");
        if (pend_valid) loaded = 1'b1;
        // idle cycles carry the last strobed row
        // so the held payload is compared through gaps too
        if (loaded) begin
            exp_oh = '0;
            exp_oh[pend_row.exp_idx] = 1'b1;
            check_count(status.req_count, pend_row.exp_count, "status.req_count");
            check_flag(status.req_single, pend_row.exp_single, "status.req_single");
            check_idx(status.min_idx, pend_row.exp_idx, "status.min_idx");
            check_total(status.occ_total, pend_row.exp_total, "status.occ_total");
            check_onehot(min_onehot, exp_oh, "min_onehot");
        end
        pend_valid = drive_valid;
        pend_row = r;
    endtask

    // strobe, then the row's idle cycles
    task automatic apply_row(input row_t r);
        run_cycle(1'b1, r);
        for (int g = 0; g < r.gap; g++) run_cycle(1'b0, r);
    endtask

    initial begin
        row_t r;
        int   drain;
        arst_n = 1'b0;
        in_valid = 1'b0;
        req = '0;
        occ = '0;
        pend_valid = 1'b0;
        loaded = 1'b0;
        lfsr_state = 16'd38356;
        load_directed();

        // outputs stay cleared through reset and after it
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            check_idle_zero();
        end
        @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_idle_zero();
        end

        for (int k = 0; k < N_DIRECTED; k++) apply_row(directed[k]);
        for (int k = 0; k < N_RANDOM; k++) begin
            make_random_row(r);
            apply_row(r);
        end
        // flush the last pending check
        run_cycle(1'b0, r);

        drain = 0;
        while (out_valid !== 1'b0) begin
            @(negedge clk);
            drain++;
            if (drain > DRAIN_LIMIT) begin
                $display("out_valid did not return low after the last row");
                $display("sim failed");
                $fatal(1, "drain timeout");
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule

//--- verilog.f
status_pkg.sv
carry_sum_gen.sv
pop_count_15.sv
pop_count_31.sv
request_counter.sv
min_finder.sv
onehot_encoder.sv
occupancy_sum.sv
vc_status_unit.sv
tb_vc_status_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vc_status_unit testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_vc_status_unit
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module "$TOP" \
    -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
